//--- bank/bank_sram_controller.sv
`timescale 1ns/1ps
`include "bank_macros.svh"

module bank_sram_controller (
  input  logic                        clk_i,
  input  logic                        rst_i,
  // issue unit
  input  logic                        isu_valid_i,
  output logic                        isu_ready_o,
  input  cache_pkg::cache_op_e        isu_opcode_i,
  input  cache_pkg::chan_t            isu_channel_i,
  input  cache_pkg::rob_t             isu_rob_i,
  input  cache_pkg::set_way_off_t     isu_set_way_offset_i,
  input  cache_pkg::wbuf_id_t         isu_wbuf_id_i,
  input  cache_pkg::line_state_e      isu_state0_i,
  input  cache_pkg::line_state_e      isu_state1_i,
  input  cache_pkg::data_t            isu_lf_data0_i,
  input  cache_pkg::data_t            isu_lf_data1_i,
  // crossbar response
  output logic                        xbar_valid_o,
  output cache_pkg::chan_t            xbar_channel_o,
  output cache_pkg::rob_t             xbar_rob_o,
  output cache_pkg::data_t            xbar_data_o,
  // write buffer and eviction
  wbuf_if.master                      wbuf,
  evict_if.master                     evict
);

  logic                     s0_is_write;
  logic                     s0_is_lf;
  logic                     s0_is_wb;
  logic                     s0_offset;
  cache_pkg::set_way_t      s0_set_way;
  logic [1:0]               s0_empty;
  logic [1:0]               s0_dirty;
  logic                     s0_cnt_q;
  logic                     s0_can_go;
  logic                     s0_accept;
  logic                     s0_wr_phase;

  logic [1:0]               arr_touch;
  logic [1:0]               arr_en;
  logic [1:0]               arr_we;
  cache_pkg::data_t         arr_wdata [2];
  cache_pkg::data_t         arr_rdata [2];

  logic                     s1_push;
  logic                     s1_pop;
  logic                     s1_allow_in;
  logic                     s1_valid_q;
  cache_pkg::cache_op_e     s1_op_q;
  logic                     s1_offset_q;
  cache_pkg::set_way_t      s1_set_way_q;
  cache_pkg::chan_t         s1_chan_q;
  cache_pkg::rob_t          s1_rob_q;
  logic [1:0]               s1_dirty_q;

  cache_pkg::data_t         lf_buf_q;
  logic [1:0]               evict_half;
  bus_pkg::evict_data_t     evict_now;
  bus_pkg::evict_data_t     evict_buf_q;
  logic                     evict_held_q;

  // ------------------------------------------------------------
  // stage 0 decode
  // ------------------------------------------------------------
  assign s0_is_write = isu_opcode_i == cache_pkg::OP_WRITE;
  assign s0_is_lf    = isu_opcode_i == cache_pkg::OP_READ_LINEFILL;
  assign s0_is_wb    = isu_opcode_i == cache_pkg::OP_WRITE_BACK;
  assign s0_set_way  = isu_set_way_offset_i[`BANK_SET_WAY_W:1];
  assign s0_offset   = isu_set_way_offset_i[0];

  assign s0_empty = {isu_state1_i == cache_pkg::LS_EMPTY, isu_state0_i == cache_pkg::LS_EMPTY};
  assign s0_dirty = {isu_state1_i == cache_pkg::LS_DIRTY, isu_state0_i == cache_pkg::LS_DIRTY};

  // writes wait one cycle for the buffer return
  assign s0_can_go   = ~s0_is_write | (s0_cnt_q & wbuf.rtn_valid);
  assign isu_ready_o = s0_can_go & s1_allow_in;
  assign s0_accept   = isu_valid_i & isu_ready_o;
  assign s0_wr_phase = s0_accept & s0_is_write;

  // buffer request only when stage 1 can take the next op
  assign wbuf.req_valid = isu_valid_i & s0_is_write & ~s0_cnt_q & s1_allow_in;
  assign wbuf.req_id    = isu_wbuf_id_i;

  // 0: idle or request phase, 1: array write phase
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      s0_cnt_q <= 1'b0;
    end else if (s0_accept) begin
      s0_cnt_q <= 1'b0;
    end else if (wbuf.req_valid) begin
      s0_cnt_q <= 1'b1;
    end
  end

  // ------------------------------------------------------------
  // data arrays
  // ------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      // selected half, plus other half on empty fill or dirty evict
      arr_touch[i] = (s0_offset == 1'(i))
                   | (s0_is_lf & s0_empty[i])
                   | (s0_is_wb & s0_dirty[i]);
      arr_en[i]    = arr_touch[i] & (s1_push | s0_wr_phase);
      arr_we[i]    = arr_touch[i] & ((s1_push & s0_is_lf) | s0_wr_phase);
    end
  end

  assign arr_wdata[0] = s0_is_write ? wbuf.rtn_data : isu_lf_data0_i;
  assign arr_wdata[1] = s0_is_write ? wbuf.rtn_data : isu_lf_data1_i;

  ram_sp half0_array (
    .clk_i   (clk_i),
    .en_i    (arr_en[0]),
    .we_i    (arr_we[0]),
    .addr_i  (s0_set_way),
    .wdata_i (arr_wdata[0]),
    .rdata_o (arr_rdata[0])
  );

  ram_sp half1_array (
    .clk_i   (clk_i),
    .en_i    (arr_en[1]),
    .we_i    (arr_we[1]),
    .addr_i  (s0_set_way),
    .wdata_i (arr_wdata[1]),
    .rdata_o (arr_rdata[1])
  );

  // ------------------------------------------------------------
  // stage 1
  // ------------------------------------------------------------
  assign s1_push     = s0_accept & ~s0_is_write;
  assign s1_pop      = s1_valid_q & ((s1_op_q != cache_pkg::OP_WRITE_BACK) | evict.ready);
  assign s1_allow_in = ~s1_valid_q | s1_pop;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
    end else if (s1_push) begin
      s1_valid_q <= 1'b1;
    end else if (s1_pop) begin
      s1_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_push) begin
      s1_op_q      <= isu_opcode_i;
      s1_offset_q  <= s0_offset;
      s1_set_way_q <= s0_set_way;
      s1_chan_q    <= isu_channel_i;
      s1_rob_q     <= isu_rob_i;
      s1_dirty_q   <= s0_dirty;
      if (s0_is_lf) begin
        lf_buf_q <= s0_offset ? isu_lf_data1_i : isu_lf_data0_i;
      end
    end
  end

  // crossbar response
  assign xbar_valid_o   = s1_valid_q & ((s1_op_q == cache_pkg::OP_READ)
                                      | (s1_op_q == cache_pkg::OP_READ_LINEFILL));
  assign xbar_data_o    = (s1_op_q == cache_pkg::OP_READ_LINEFILL) ? lf_buf_q
                                                                   : arr_rdata[s1_offset_q];
  assign xbar_channel_o = s1_chan_q;
  assign xbar_rob_o     = s1_rob_q;

  // ------------------------------------------------------------
  // eviction
  // ------------------------------------------------------------
  assign evict_half[0] = ~s1_offset_q | s1_dirty_q[0];
  assign evict_half[1] =  s1_offset_q | s1_dirty_q[1];

  assign evict_now.half0 = evict_half[0] ? arr_rdata[0] : '0;
  assign evict_now.half1 = evict_half[1] ? arr_rdata[1] : '0;

  // first cycle straight from the arrays, held copy afterwards
  always_ff @(posedge clk_i) begin
    if (evict.valid & ~evict_held_q) begin
      evict_buf_q <= evict_now;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      evict_held_q <= 1'b0;
    end else if (s1_pop) begin
      evict_held_q <= 1'b0;
    end else if (evict.valid) begin
      evict_held_q <= 1'b1;
    end
  end

  assign evict.valid   = s1_valid_q & (s1_op_q == cache_pkg::OP_WRITE_BACK);
  assign evict.data    = evict_held_q ? evict_buf_q : evict_now;
  assign evict.strb    = {{(`BANK_DATA_W/8){evict_half[1]}}, {(`BANK_DATA_W/8){evict_half[0]}}};
  assign evict.set_way = s1_set_way_q;

endmodule

//--- bank/ram_sp.sv
`timescale 1ns/1ps
`include "bank_macros.svh"

module ram_sp (
  input  logic                       clk_i,
  input  logic                       en_i,
  input  logic                       we_i,
  input  logic [`BANK_SET_WAY_W-1:0] addr_i,
  input  logic [`BANK_DATA_W-1:0]    wdata_i,
  output logic [`BANK_DATA_W-1:0]    rdata_o
);

  logic [`BANK_DATA_W-1:0] mem [`BANK_ARRAY_DEPTH];

  // output holds its value on idle and write cycles
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

//--- common/bank_if.sv
`timescale 1ns/1ps

// ----------------------------------------------------------
// controller to write buffer store
// ----------------------------------------------------------
interface wbuf_if;
  logic                req_valid;
  cache_pkg::wbuf_id_t req_id;
  logic                rtn_valid;
  cache_pkg::data_t    rtn_data;

  modport master (output req_valid, output req_id, input rtn_valid, input rtn_data);
  modport slave  (input req_valid, input req_id, output rtn_valid, output rtn_data);
endinterface

// ----------------------------------------------------------
// controller to wishbone eviction master
// ----------------------------------------------------------
interface evict_if;
  logic                  valid;
  logic                  ready;
  bus_pkg::evict_data_t  data;
  bus_pkg::evict_strb_t  strb;
  cache_pkg::set_way_t   set_way;

  // payload held until ready
  modport master (
    output valid, output data, output strb, output set_way,
    input  ready
  );
  modport slave (
    input  valid, input data, input strb, input set_way,
    output ready
  );
endinterface

//--- common/bank_macros.svh
`ifndef BANK_MACROS_SVH
`define BANK_MACROS_SVH

// data array geometry
`define BANK_DATA_W      128
`define BANK_SET_WAY_W   6
`define BANK_ARRAY_DEPTH (1 << `BANK_SET_WAY_W)

// write buffer
`define BANK_WBUF_ID_W   8
`define BANK_WBUF_DEPTH  256

// crossbar response tags
`define BANK_ROB_W       3
`define BANK_CHAN_W      2

`endif

//--- common/bus_pkg.sv
`include "bank_macros.svh"

package bus_pkg;

  // wishbone master cycle state
  typedef enum logic [0:0] {
    WB_IDLE = 1'b0,
    WB_BUSY = 1'b1
  } wb_state_e;

  // one evicted line, half1 in the upper bits
  typedef struct packed {
    logic [`BANK_DATA_W-1:0] half1;
    logic [`BANK_DATA_W-1:0] half0;
  } evict_data_t;

  // byte enables, one group per half
  typedef logic [2*`BANK_DATA_W/8-1:0] evict_strb_t;

endpackage

//--- common/cache_pkg.sv
`include "bank_macros.svh"

package cache_pkg;

  // issue unit opcodes
  typedef enum logic [2:0] {
    OP_WRITE         = 3'd0,
    OP_READ          = 3'd1,
    OP_READ_LINEFILL = 3'd2,
    OP_WRITE_BACK    = 3'd3
  } cache_op_e;

  // state of one half-line as reported by the issuer
  typedef enum logic [1:0] {
    LS_EMPTY = 2'd0,
    LS_SYNC  = 2'd1,
    LS_DIRTY = 2'd2
  } line_state_e;

  // ----------------------------------------------------------
  // issue request fields
  // ----------------------------------------------------------
  typedef logic [`BANK_CHAN_W-1:0]    chan_t;
  typedef logic [`BANK_ROB_W-1:0]     rob_t;
  typedef logic [`BANK_SET_WAY_W-1:0] set_way_t;

  // set_way in the upper bits, half offset in bit 0
  typedef logic [`BANK_SET_WAY_W:0]   set_way_off_t;

  typedef logic [`BANK_WBUF_ID_W-1:0] wbuf_id_t;
  typedef logic [`BANK_DATA_W-1:0]    data_t;

endpackage

//--- hdl/bank_top.sv
`timescale 1ns/1ps

module bank_top (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // issue request
  input  logic                    isu_valid_i,
  output logic                    isu_ready_o,
  input  cache_pkg::cache_op_e    isu_opcode_i,
  input  cache_pkg::chan_t        isu_channel_i,
  input  cache_pkg::rob_t         isu_rob_i,
  input  cache_pkg::set_way_off_t isu_set_way_offset_i,
  input  cache_pkg::wbuf_id_t     isu_wbuf_id_i,
  input  cache_pkg::line_state_e  isu_state0_i,
  input  cache_pkg::line_state_e  isu_state1_i,
  input  cache_pkg::data_t        isu_lf_data0_i,
  input  cache_pkg::data_t        isu_lf_data1_i,
  // crossbar response
  output logic                    xbar_valid_o,
  output cache_pkg::chan_t        xbar_channel_o,
  output cache_pkg::rob_t         xbar_rob_o,
  output cache_pkg::data_t        xbar_data_o,
  // write buffer fill
  input  logic                    fill_valid_i,
  input  cache_pkg::wbuf_id_t     fill_id_i,
  input  cache_pkg::data_t        fill_data_i,
  // wishbone master
  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  output logic                    wb_we_o,
  output cache_pkg::set_way_t     wb_adr_o,
  output bus_pkg::evict_data_t    wb_dat_o,
  output bus_pkg::evict_strb_t    wb_sel_o,
  input  logic                    wb_ack_i
);

  wbuf_if  wbuf ();
  evict_if evict ();

  bank_sram_controller u_ctrl (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .isu_valid_i          (isu_valid_i),
    .isu_ready_o          (isu_ready_o),
    .isu_opcode_i         (isu_opcode_i),
    .isu_channel_i        (isu_channel_i),
    .isu_rob_i            (isu_rob_i),
    .isu_set_way_offset_i (isu_set_way_offset_i),
    .isu_wbuf_id_i        (isu_wbuf_id_i),
    .isu_state0_i         (isu_state0_i),
    .isu_state1_i         (isu_state1_i),
    .isu_lf_data0_i       (isu_lf_data0_i),
    .isu_lf_data1_i       (isu_lf_data1_i),
    .xbar_valid_o         (xbar_valid_o),
    .xbar_channel_o       (xbar_channel_o),
    .xbar_rob_o           (xbar_rob_o),
    .xbar_data_o          (xbar_data_o),
    .wbuf                 (wbuf.master),
    .evict                (evict.master)
  );

  wbuf_store u_wbuf (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .fill_valid_i (fill_valid_i),
    .fill_id_i    (fill_id_i),
    .fill_data_i  (fill_data_i),
    .wbuf         (wbuf.slave)
  );

  wb_evict_master u_wb_master (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .evict    (evict.slave),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .wb_we_o  (wb_we_o),
    .wb_adr_o (wb_adr_o),
    .wb_dat_o (wb_dat_o),
    .wb_sel_o (wb_sel_o),
    .wb_ack_i (wb_ack_i)
  );

endmodule

//--- hdl/wb_evict_master.sv
`timescale 1ns/1ps

module wb_evict_master (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // eviction from the controller
  evict_if.slave               evict,
  // wishbone classic master
  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  output logic                 wb_we_o,
  output cache_pkg::set_way_t  wb_adr_o,
  output bus_pkg::evict_data_t wb_dat_o,
  output bus_pkg::evict_strb_t wb_sel_o,
  input  logic                 wb_ack_i
);

  bus_pkg::wb_state_e   state_q;
  logic                 busy;
  logic                 launch;
  cache_pkg::set_way_t  adr_q;
  bus_pkg::evict_data_t dat_q;
  bus_pkg::evict_strb_t sel_q;

  assign busy   = state_q == bus_pkg::WB_BUSY;
  assign launch = (state_q == bus_pkg::WB_IDLE) & evict.valid;

  // ----------------------------------------------------------
  // cycle state
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= bus_pkg::WB_IDLE;
    end else begin
      case (state_q)
        bus_pkg::WB_IDLE: begin
          if (evict.valid) begin
            state_q <= bus_pkg::WB_BUSY;
          end
        end
        bus_pkg::WB_BUSY: begin
          // one single write per eviction
          if (wb_ack_i) begin
            state_q <= bus_pkg::WB_IDLE;
          end
        end
        default: state_q <= bus_pkg::WB_IDLE;
      endcase
    end
  end

  // payload captured when the cycle starts
  always_ff @(posedge clk_i) begin
    if (launch) begin
      adr_q <= evict.set_way;
      dat_q <= evict.data;
      sel_q <= evict.strb;
    end
  end

  // ----------------------------------------------------------
  // bus outputs
  // ----------------------------------------------------------
  assign wb_cyc_o = busy;
  assign wb_stb_o = busy;
  assign wb_we_o  = busy;
  assign wb_adr_o = adr_q;
  assign wb_dat_o = dat_q;
  assign wb_sel_o = sel_q;

  // controller retires the write back on ack
  assign evict.ready = busy & wb_ack_i;

endmodule

//--- hdl/wbuf_store.sv
`timescale 1ns/1ps
`include "bank_macros.svh"

module wbuf_store (
  input  logic                clk_i,
  input  logic                rst_i,
  // fill from outside
  input  logic                fill_valid_i,
  input  cache_pkg::wbuf_id_t fill_id_i,
  input  cache_pkg::data_t    fill_data_i,
  // read by id from the controller
  wbuf_if.slave               wbuf
);

  cache_pkg::data_t mem [`BANK_WBUF_DEPTH];
  cache_pkg::data_t rtn_data_q;
  logic             rtn_valid_q;

  // ----------------------------------------------------------
  // storage
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (fill_valid_i) begin
      mem[fill_id_i] <= fill_data_i;
    end
  end

  // ----------------------------------------------------------
  // return path, one cycle after the request
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (wbuf.req_valid) begin
      rtn_data_q <= mem[wbuf.req_id];
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rtn_valid_q <= 1'b0;
    end else begin
      rtn_valid_q <= wbuf.req_valid;
    end
  end

  assign wbuf.rtn_valid = rtn_valid_q;
  assign wbuf.rtn_data  = rtn_data_q;

endmodule

//--- run.sh
#!/bin/bash
# compile with Verilator and run; the exit status is the test result
verilator --binary --timing --assert -j 0 -f sim.f --top-module bank_tb -o vbank_tb \
  && ./obj_dir/vbank_tb \
  || exit 1

//--- sim.f
+incdir+common
common/cache_pkg.sv
common/bus_pkg.sv
common/bank_if.sv
bank/ram_sp.sv
bank/bank_sram_controller.sv
hdl/wbuf_store.sv
hdl/wb_evict_master.sv
hdl/bank_top.sv
test/bank_chk.sv
test/bank_tb.sv

//--- test/bank_chk.sv
`timescale 1ns/1ps
`include "bank_macros.svh"

module bank_chk (
  input logic                    clk_i,
  input logic                    rst_i,
  input logic                    isu_valid_i,
  input logic                    isu_ready_i,
  input cache_pkg::cache_op_e    isu_opcode_i,
  input cache_pkg::set_way_off_t isu_set_way_offset_i,
  input cache_pkg::wbuf_id_t     isu_wbuf_id_i,
  input logic                    wbuf_req_i,
  input logic                    wbuf_rtn_i,
  input logic                    evict_valid_i,
  input logic                    evict_ready_i,
  input bus_pkg::evict_data_t    evict_data_i,
  input bus_pkg::evict_strb_t    evict_strb_i,
  input cache_pkg::set_way_t     evict_set_way_i,
  input logic                    wb_cyc_i,
  input logic                    wb_stb_i,
  input logic                    wb_ack_i
);

  // issue request held until accepted
  issue_stable_a : assert property (@(posedge clk_i) disable iff (rst_i)
    isu_valid_i && !isu_ready_i |=> isu_valid_i && $stable(isu_opcode_i)
      && $stable(isu_set_way_offset_i) && $stable(isu_wbuf_id_i))
    else $error("issue request changed before ready");

  // buffer return one cycle after each request, write taken with it
  wbuf_rtn_a : assert property (@(posedge clk_i) disable iff (rst_i)
    wbuf_req_i |=> wbuf_rtn_i && isu_ready_i)
    else $error("write buffer return missing or write not taken with it");

  evict_stable_a : assert property (@(posedge clk_i) disable iff (rst_i)
    evict_valid_i && !evict_ready_i |=> evict_valid_i && $stable(evict_data_i)
      && $stable(evict_strb_i) && $stable(evict_set_way_i))
    else $error("eviction payload changed before ready");

  // open wishbone write keeps the issue port blocked until ack
  stb_in_cyc_a : assert property (@(posedge clk_i) disable iff (rst_i)
    wb_stb_i && !wb_ack_i |-> wb_cyc_i && !isu_ready_i)
    else $error("stb without cyc or issue ready high before ack");

endmodule

bind bank_top bank_chk i_chk (
  .clk_i                (clk_i),
  .rst_i                (rst_i),
  .isu_valid_i          (isu_valid_i),
  .isu_ready_i          (isu_ready_o),
  .isu_opcode_i         (isu_opcode_i),
  .isu_set_way_offset_i (isu_set_way_offset_i),
  .isu_wbuf_id_i        (isu_wbuf_id_i),
  .wbuf_req_i           (wbuf.req_valid),
  .wbuf_rtn_i           (wbuf.rtn_valid),
  .evict_valid_i        (evict.valid),
  .evict_ready_i        (evict.ready),
  .evict_data_i         (evict.data),
  .evict_strb_i         (evict.strb),
  .evict_set_way_i      (evict.set_way),
  .wb_cyc_i             (wb_cyc_o),
  .wb_stb_i             (wb_stb_o),
  .wb_ack_i             (wb_ack_i)
);

//--- test/bank_tb.sv
`timescale 1ns/1ps
`include "bank_macros.svh"

module bank_tb;

  logic                    clk_i;
  logic                    rst_i;
  logic                    isu_valid_i;
  logic                    isu_ready_o;
  cache_pkg::cache_op_e    isu_opcode_i;
  cache_pkg::chan_t        isu_channel_i;
  cache_pkg::rob_t         isu_rob_i;
  cache_pkg::set_way_off_t isu_set_way_offset_i;
  cache_pkg::wbuf_id_t     isu_wbuf_id_i;
  cache_pkg::line_state_e  isu_state0_i;
  cache_pkg::line_state_e  isu_state1_i;
  cache_pkg::data_t        isu_lf_data0_i;
  cache_pkg::data_t        isu_lf_data1_i;
  logic                    xbar_valid_o;
  cache_pkg::chan_t        xbar_channel_o;
  cache_pkg::rob_t         xbar_rob_o;
  cache_pkg::data_t        xbar_data_o;
  logic                    fill_valid_i;
  cache_pkg::wbuf_id_t     fill_id_i;
  cache_pkg::data_t        fill_data_i;
  logic                    wb_cyc_o;
  logic                    wb_stb_o;
  logic                    wb_we_o;
  cache_pkg::set_way_t     wb_adr_o;
  bus_pkg::evict_data_t    wb_dat_o;
  bus_pkg::evict_strb_t    wb_sel_o;
  logic                    wb_ack_i;

  // columns read from the test file
  int           t_op [$];
  int           t_chan [$];
  int           t_rob [$];
  int           t_swo [$];
  int           t_wid [$];
  int           t_st0 [$];
  int           t_st1 [$];
  logic [255:0] t_lf0 [$];
  logic [255:0] t_lf1 [$];
  logic [255:0] t_sel [$];
  logic [255:0] t_exp [$];
  int           n_tests = 0;
  int           fails = 0;

  // reference contents
  logic [127:0] ref_h0 [64];
  logic [127:0] ref_h1 [64];
  logic [127:0] ref_wbuf [256];

  bank_top i_dut (.*);

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  task automatic check(input string name, input logic [255:0] got, input logic [255:0] exp);
    if (got !== exp) begin
      fails++;
      $display("Fail %s: got %h expected %h", name, got, exp);
      $display("Some tests failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic load_tests();
    int    fd;
    int    n;
    int    op, chan, rob, swo, wid, st0, st1;
    logic [255:0] lf0, lf1, sel, exp;
    string line;
    fd = $fopen("test/bank_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test file");
      $display("Some tests failed");
      $fatal(1, "no test file");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                    op, chan, rob, swo, wid, st0, st1, lf0, lf1, sel, exp);
        if (n != 11) begin
          $display("malformed test line: %s", line);
          $display("Some tests failed");
          $fatal(1, "bad test file");
        end
        t_op.push_back(op);
        t_chan.push_back(chan);
        t_rob.push_back(rob);
        t_swo.push_back(swo);
        t_wid.push_back(wid);
        t_st0.push_back(st0);
        t_st1.push_back(st1);
        t_lf0.push_back(lf0);
        t_lf1.push_back(lf1);
        t_sel.push_back(sel);
        t_exp.push_back(exp);
      end
    end
    $fclose(fd);
    n_tests = t_op.size();
  endtask

  // ------------------------------------------------------------
  // memory slave: ack after a random delay
  // ------------------------------------------------------------
  task automatic slave_ack(input logic [255:0] exp_sel, input logic [255:0] exp_dat,
                           input int set_way);
    int delay;
    delay = int'($urandom_range(3, 0));
    // evict valid in this cycle, cyc and stb from the next edge
    #10;
    check("isu_ready_o", 256'(isu_ready_o), 256'(0));
    @(negedge clk_i);
    check("wb_cyc_o", 256'(wb_cyc_o), 256'(1));
    check("wb_stb_o", 256'(wb_stb_o), 256'(1));
    repeat (delay) begin
      #10;
      check("isu_ready_o", 256'(isu_ready_o), 256'(0));
      check("wb_stb_o", 256'(wb_stb_o), 256'(1));
      @(negedge clk_i);
    end
    check("wb_we_o", 256'(wb_we_o), 256'(1));
    check("wb_adr_o", 256'(wb_adr_o), 256'(set_way));
    check("wb_sel_o", 256'(wb_sel_o), exp_sel);
    check("wb_dat_o", 256'(wb_dat_o), exp_dat);
    wb_ack_i = 1'b1;
    @(negedge clk_i);
    wb_ack_i = 1'b0;
    check("wb_cyc_o", 256'(wb_cyc_o), 256'(0));
    check("wb_stb_o", 256'(wb_stb_o), 256'(0));
  endtask

  task automatic run_op(input int i);
    int           cycles;
    logic         accepted;
    logic         off;
    int           sw;
    logic [127:0] exp_rd;
    logic [255:0] exp_sel;
    logic [255:0] exp_dat;
    off = t_swo[i][0];
    sw = t_swo[i] >> 1;
    if (t_op[i] == 'hf) begin
      fill_valid_i = 1'b1;
      fill_id_i    = 8'(t_wid[i]);
      fill_data_i  = t_lf0[i][127:0];
      ref_wbuf[t_wid[i]] = t_lf0[i][127:0];
      @(negedge clk_i);
      fill_valid_i = 1'b0;
      return;
    end
    isu_valid_i          = 1'b1;
    isu_opcode_i         = cache_pkg::cache_op_e'(t_op[i][2:0]);
    isu_channel_i        = 2'(t_chan[i]);
    isu_rob_i            = 3'(t_rob[i]);
    isu_set_way_offset_i = 7'(t_swo[i]);
    isu_wbuf_id_i        = 8'(t_wid[i]);
    isu_state0_i         = cache_pkg::line_state_e'(t_st0[i][1:0]);
    isu_state1_i         = cache_pkg::line_state_e'(t_st1[i][1:0]);
    isu_lf_data0_i       = t_lf0[i][127:0];
    isu_lf_data1_i       = t_lf1[i][127:0];
    cycles = 0;
    accepted = 1'b0;
    while (!accepted) begin
      #10;
      accepted = isu_ready_o;
      @(posedge clk_i);
      cycles++;
      if (!accepted) @(negedge clk_i);
    end
    @(negedge clk_i);
    isu_valid_i = 1'b0;
    case (t_op[i])
      0: begin
        check("write cycles >= 2", 256'(cycles >= 2), 256'(1));
        check("xbar_valid_o", 256'(xbar_valid_o), 256'(0));
        if (off) ref_h1[sw] = ref_wbuf[t_wid[i]];
        else ref_h0[sw] = ref_wbuf[t_wid[i]];
      end
      1, 2: begin
        if (t_op[i] == 2) begin
          // selected half always filled, other half only if empty
          if (!off || t_st0[i] == 0) ref_h0[sw] = t_lf0[i][127:0];
          if (off || t_st1[i] == 0) ref_h1[sw] = t_lf1[i][127:0];
        end
        exp_rd = off ? ref_h1[sw] : ref_h0[sw];
        check("file expected data", t_exp[i], 256'(exp_rd));
        check("xbar_valid_o", 256'(xbar_valid_o), 256'(1));
        check("xbar_channel_o", 256'(xbar_channel_o), 256'(t_chan[i]));
        check("xbar_rob_o", 256'(xbar_rob_o), 256'(t_rob[i]));
        check("xbar_data_o", 256'(xbar_data_o), 256'(exp_rd));
        @(negedge clk_i);
        check("xbar_valid_o", 256'(xbar_valid_o), 256'(0));
      end
      default: begin
        exp_sel = '0;
        exp_dat = '0;
        if (!off || t_st0[i] == 2) begin
          exp_sel[15:0] = 16'hffff;
          exp_dat[127:0] = ref_h0[sw];
        end
        if (off || t_st1[i] == 2) begin
          exp_sel[31:16] = 16'hffff;
          exp_dat[255:128] = ref_h1[sw];
        end
        check("file expected sel", t_sel[i], exp_sel);
        check("file expected data", t_exp[i], exp_dat);
        slave_ack(exp_sel, exp_dat, sw);
      end
    endcase
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(32'h83c7));
    rst_i                = 1'b1;
    isu_valid_i          = 1'b0;
    isu_opcode_i         = cache_pkg::OP_READ;
    isu_channel_i        = '0;
    isu_rob_i            = '0;
    isu_set_way_offset_i = '0;
    isu_wbuf_id_i        = '0;
    isu_state0_i         = cache_pkg::LS_EMPTY;
    isu_state1_i         = cache_pkg::LS_EMPTY;
    isu_lf_data0_i       = '0;
    isu_lf_data1_i       = '0;
    fill_valid_i         = 1'b0;
    fill_id_i            = '0;
    fill_data_i          = '0;
    wb_ack_i             = 1'b0;
    load_tests();
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    #10;
    check("isu_ready_o", 256'(isu_ready_o), 256'(1));
    check("xbar_valid_o", 256'(xbar_valid_o), 256'(0));
    check("wb_cyc_o", 256'(wb_cyc_o), 256'(0));
    check("wb_stb_o", 256'(wb_stb_o), 256'(0));
    @(negedge clk_i);
    for (int i = 0; i < n_tests; i++) begin
      run_op(i);
      repeat ($urandom_range(3, 0)) @(negedge clk_i);
    end
    if (fails == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("Some tests failed");
      $fatal(1, "checks failed");
    end
  end

  // watchdog, 50 cycles per test line
  initial begin
    wait (n_tests > 0);
    #((n_tests * 50 + 20) * 40);
    $display("run did not finish in time");
    $display("Some tests failed");
    $fatal(1, "timeout");
  end

endmodule

//--- test/bank_tests.txt
# op chan rob swo wid st0 st1 lf0 lf1 sel exp (hex); op f = buffer fill, lf0 holds the data
# swo = {set_way, offset}; state 0 empty, 1 sync, 2 dirty; sel and exp checked on write back
f 0 0 00 01 0 0 a1 0 0 0
f 0 0 00 02 0 0 a2 0 0 0
f 0 0 00 03 0 0 b1 0 0 0
f 0 0 00 04 0 0 b2 0 0 0
0 0 0 0a 01 2 2 0 0 0 0
0 0 0 0b 02 2 2 0 0 0 0
0 0 0 12 03 0 0 0 0 0 0
0 0 0 13 04 0 0 0 0 0 0
1 1 2 0a 00 1 1 0 0 0 a1
1 2 5 0b 00 1 1 0 0 0 a2
1 3 7 12 00 1 1 0 0 0 b1
1 0 1 13 00 1 1 0 0 0 b2
2 1 3 28 00 0 0 d0 d1 0 d0
1 1 4 29 00 1 1 0 0 0 d1
2 2 6 0a 00 1 1 e0 e1 0 e0
1 2 0 0b 00 1 1 0 0 0 a2
1 3 1 0a 00 1 1 0 0 0 e0
3 0 0 13 00 1 2 0 0 ffff0000 b200000000000000000000000000000000
3 0 0 12 00 2 1 0 0 0000ffff b1
3 0 0 0a 00 2 2 0 0 ffffffff a2000000000000000000000000000000e0
3 0 0 29 00 2 2 0 0 ffffffff d1000000000000000000000000000000d0
1 0 2 12 00 1 1 0 0 0 b1
